//--- source/rtcMenu_settings.svh
// RTC front panel settings: register map, bus widths and the pause between sweeps
`ifndef RTC_MENU_SETTINGS_SVH
`define RTC_MENU_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////
`define RTC_ADDR_W 8        // RTC register address
`define CURSOR_W   7        // Edit cursor, covers 0x21..0x44

//////////////////////////////////////////////////////////////////////
// Sweep timing
//////////////////////////////////////////////////////////////////////
`define WAIT_CYCLES 3       // Idle cycles between two sweeps

//////////////////////////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////////////////////////
// Time group, seconds up to year
`define TIME_FIRST 8'h21
`define TIME_LAST  8'h27

// Date group
`define DATE_FIRST 8'h41
`define DATE_LAST  8'h44

// Service registers, at most one per sweep
`define TIMER_REG  8'h00    // Timer start
`define ALARM_REG  8'h01    // Alarm stop
`define CMD_REG    8'hF0    // Transfer command, closes every sweep

`endif

//--- source/rtcMenuPkg.sv
// RTC front panel package: shared address, button, request and sweep state types
`include "rtcMenu_settings.svh"

package rtcMenuPkg;

	//////////////////////////////////////////////////////////////////////
	// Bus types
	//////////////////////////////////////////////////////////////////////

	// One RTC register address
	typedef logic [`RTC_ADDR_W-1:0] rtcAddr_t;

	// Single register access toward the RTC
	typedef struct packed
	{
		rtcAddr_t addr;     // Register to visit
		logic     write;    // High for a modifying access
	} rtcRequest_t;

	//////////////////////////////////////////////////////////////////////
	// Front panel inputs
	//////////////////////////////////////////////////////////////////////

	// Rising-edge pulses, one cycle each
	// Field order follows the raw button vector, up is the MSB
	typedef struct packed
	{
		logic up;           // Mark sweep as modifying
		logic down;         // Same effect as up
		logic left;         // Cursor forward
		logic right;        // Cursor backward
		logic timerStart;   // Request a timer register visit
	} buttonPulses_t;

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////

	// Sweep FSM states
	typedef enum logic [1:0]
	{
		IDLE     = 2'd0,    // Only right after reset
		ISSUE    = 2'd1,    // Start pulse toward the requester
		WAITDONE = 2'd2,    // Access in flight
		PAUSE    = 2'd3     // Gap between sweeps
	} sweepState_t;

endpackage

//--- source/buttonEdges.sv
// Button edge detector: synchronizes raw panel inputs and emits one-cycle rising-edge pulses
`timescale 1ns/1ps

module buttonEdges
(
	input  logic                      CLK,
	input  logic                      RST,
	input  logic [4:0]                buttons,  // up, down, left, right, timerStart
	output rtcMenuPkg::buttonPulses_t pulses
);

	logic [4:0] syncMeta;   // First stage, may go metastable
	logic [4:0] syncOut;    // Settled level
	logic [4:0] prevOut;    // Level one cycle back
	logic [4:0] rise;       // Low to high seen this cycle

	//////////////////////////////////////////////////////////////////////
	// Synchronizer and history
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			syncMeta <= '0;
			syncOut  <= '0;
			prevOut  <= '0;  // Held-down button after reset gives no pulse until synced
		end
		else
		begin
			syncMeta <= buttons;
			syncOut  <= syncMeta;
			prevOut  <= syncOut;
		end
	end

	// Edge detect, pulse lands two cycles after the raw rise
	assign rise = syncOut & ~prevOut;

	//////////////////////////////////////////////////////////////////////
	// Pack into the pulse struct
	//////////////////////////////////////////////////////////////////////
	assign pulses.up         = rise[4];
	assign pulses.down       = rise[3];
	assign pulses.left       = rise[2];
	assign pulses.right      = rise[1];
	assign pulses.timerStart = rise[0];

endmodule

//--- source/editCursor.sv
// Edit cursor: steps over the time and date registers with group jumps, tracks the modify flag
`timescale 1ns/1ps
`include "rtcMenu_settings.svh"

module editCursor
(
	input  logic                      CLK,
	input  logic                      RST,
	input  rtcMenuPkg::buttonPulses_t pulses,
	input  logic                      sweepEnd,       // Sequencer closed a sweep
	output logic [`CURSOR_W-1:0]      cursor,
	output logic                      modifyPending
);

	// Group limits at cursor width
	localparam logic [`CURSOR_W-1:0] curTimeFirst = `CURSOR_W'(`TIME_FIRST);
	localparam logic [`CURSOR_W-1:0] curTimeLast  = `CURSOR_W'(`TIME_LAST);
	localparam logic [`CURSOR_W-1:0] curDateFirst = `CURSOR_W'(`DATE_FIRST);
	localparam logic [`CURSOR_W-1:0] curDateLast  = `CURSOR_W'(`DATE_LAST);

	logic [`CURSOR_W-1:0] cursorNext;

	//////////////////////////////////////////////////////////////////////
	// Cursor step
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		cursorNext = cursor;                     // Both or none pressed, stay
		if (pulses.left && !pulses.right)
		begin
			case (cursor)
				curTimeLast: cursorNext = curDateFirst;  // Jump the gap forward
				curDateLast: cursorNext = curTimeFirst;  // Wrap to the start
				default:     cursorNext = cursor + 1'b1;
			endcase
		end
		else if (pulses.right && !pulses.left)
		begin
			case (cursor)
				curTimeFirst: cursorNext = curDateLast;  // Wrap to the end
				curDateFirst: cursorNext = curTimeLast;  // Jump the gap back
				default:      cursorNext = cursor - 1'b1;
			endcase
		end
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			cursor        <= curTimeFirst;
			modifyPending <= 1'b0;
		end
		else
		begin
			cursor <= cursorNext;
			// New press beats the end of sweep
			if (pulses.up || pulses.down)
				modifyPending <= 1'b1;
			else if (sweepEnd)
				modifyPending <= 1'b0;
		end
	end

endmodule

//--- source/sweepSequencer.sv
// Sweep sequencer: walks the RTC register map, adds a service register, then pauses
`timescale 1ns/1ps
`include "rtcMenu_settings.svh"

module sweepSequencer
(
	input  logic                      CLK,
	input  logic                      RST,
	input  rtcMenuPkg::buttonPulses_t pulses,
	input  logic                      alarmStop,      // Level, checked after the date group
	input  logic                      modifyPending,  // From the cursor block
	input  logic                      done,           // Access finished
	output logic                      start,
	output rtcMenuPkg::rtcRequest_t   request,
	output logic                      sweepEnd
);
	import rtcMenuPkg::*;

	// Counter just wide enough for the pause length
	localparam int PauseW = $clog2(`WAIT_CYCLES + 1);

	sweepState_t       state;
	sweepState_t       stateNext;
	rtcAddr_t          addr;          // Register of the current access
	rtcAddr_t          addrNext;      // Register after it within the sweep
	logic              timerPending;  // Timer edge waiting for its visit
	logic              timerTake;     // Walk picks the timer register next
	logic              advance;       // Current access just completed
	logic              lastAccess;    // Current access is the command register
	logic [PauseW-1:0] pauseCnt;      // Cycles left in PAUSE

	assign advance    = (state == WAITDONE) && done;
	assign lastAccess = (addr == `CMD_REG);

	//////////////////////////////////////////////////////////////////////
	// Register walk
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		timerTake = 1'b0;
		case (addr)
			`TIME_LAST:
				addrNext = `DATE_FIRST;     // Jump to the date group
			`DATE_LAST:
			begin
				// One service register at most, timer first
				if (timerPending)
				begin
					addrNext  = `TIMER_REG;
					timerTake = 1'b1;
				end
				else if (alarmStop)
					addrNext = `ALARM_REG;
				else
					addrNext = `CMD_REG;
			end
			`TIMER_REG, `ALARM_REG:
				addrNext = `CMD_REG;        // Service done, close the sweep
			default:
				addrNext = addr + 1'b1;     // Next register in the group
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Sweep FSM
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		stateNext = state;
		case (state)
			IDLE:
				stateNext = ISSUE;          // First sweep right after reset
			ISSUE:
				stateNext = WAITDONE;       // Start pulse lasts one cycle
			WAITDONE:
			begin
				if (done)
					stateNext = lastAccess ? PAUSE : ISSUE;
			end
			PAUSE:
			begin
				if (pauseCnt == '0)
					stateNext = ISSUE;
			end
			default:
				stateNext = IDLE;
		endcase
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			state        <= IDLE;
			addr         <= `TIME_FIRST;
			pauseCnt     <= '0;
			timerPending <= 1'b0;
		end
		else
		begin
			state <= stateNext;

			// Address and pause counter
			if (advance)
			begin
				if (lastAccess)
				begin
					addr     <= `TIME_FIRST;                    // Next sweep restarts here
					pauseCnt <= PauseW'(`WAIT_CYCLES - 1);
				end
				else
					addr <= addrNext;
			end
			else if (state == PAUSE)
				pauseCnt <= pauseCnt - 1'b1;

			// A fresh edge wins over the clear so it is not lost
			if (pulses.timerStart)
				timerPending <= 1'b1;
			else if (advance && timerTake)
				timerPending <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////////////////////////
	assign start    = (state == ISSUE);
	assign sweepEnd = advance && lastAccess;    // Clears the modify flag in the cursor

	// Write flag follows the pending modify at the start cycle
	assign request.addr  = addr;
	assign request.write = modifyPending;

endmodule

//--- source/rtcBusRequester.sv
// RTC bus requester: four-phase req/ack master that carries one register request at a time
`timescale 1ns/1ps

module rtcBusRequester
(
	input  logic                    CLK,
	input  logic                    RST,
	input  logic                    start,      // Only taken while idle
	input  rtcMenuPkg::rtcRequest_t request,
	output logic                    done,       // One cycle after ack low
	output rtcMenuPkg::rtcRequest_t rtcReq,
	output logic                    req,
	input  logic                    ack
);

	// Handshake phases
	typedef enum logic [1:0]
	{
		reqIdle,        // Waiting for start
		reqAckHigh,     // req up, waiting for ack
		reqAckLow       // req down, waiting for ack release
	} busState_t;

	busState_t state;

	//////////////////////////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			state <= reqIdle;
			done  <= 1'b0;
		end
		else
		begin
			done <= 1'b0;                    // Pulse only
			case (state)
				reqIdle:
				begin
					if (start)
						state <= reqAckHigh;
				end
				reqAckHigh:
				begin
					if (ack)
						state <= reqAckLow;  // Drop req next
				end
				reqAckLow:
				begin
					if (!ack)
					begin
						state <= reqIdle;
						done  <= 1'b1;
					end
				end
				default:
					state <= reqIdle;
			endcase
		end
	end

	// Request held until the next start, so stable over the whole handshake
	always_ff @(posedge CLK)
	begin
		if (state == reqIdle && start)
			rtcReq <= request;
	end

	assign req = (state == reqAckHigh);

endmodule

//--- source/rtcMenuTop.sv
// RTC menu top: button edges feed the sweep sequencer and cursor, which drive the bus requester
`timescale 1ns/1ps
`include "rtcMenu_settings.svh"

module rtcMenuTop
(
	input  logic                    CLK,
	input  logic                    RST,
	input  logic [4:0]              buttons,        // Raw up, down, left, right, timerStart
	input  logic                    alarmStop,
	input  logic                    ack,
	output logic                    req,
	output rtcMenuPkg::rtcRequest_t rtcReq,
	output logic [`CURSOR_W-1:0]    cursor,
	output logic                    modifyPending
);
	import rtcMenuPkg::*;

	buttonPulses_t pulses;      // Input side to processing part
	rtcRequest_t   request;     // Sequencer to requester
	logic          start;
	logic          done;
	logic          sweepEnd;    // Sequencer to cursor

	//////////////////////////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////////////////////////
	buttonEdges uEdges
	(
		.CLK    (CLK),
		.RST    (RST),
		.buttons(buttons),
		.pulses (pulses)
	);

	//////////////////////////////////////////////////////////////////////
	// Processing part
	//////////////////////////////////////////////////////////////////////
	sweepSequencer uSequencer
	(
		.CLK          (CLK),
		.RST          (RST),
		.pulses       (pulses),
		.alarmStop    (alarmStop),
		.modifyPending(modifyPending),
		.done         (done),
		.start        (start),
		.request      (request),
		.sweepEnd     (sweepEnd)
	);

	editCursor uCursor
	(
		.CLK          (CLK),
		.RST          (RST),
		.pulses       (pulses),
		.sweepEnd     (sweepEnd),
		.cursor       (cursor),
		.modifyPending(modifyPending)
	);

	//////////////////////////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////////////////////////
	rtcBusRequester uRequester
	(
		.CLK    (CLK),
		.RST    (RST),
		.start  (start),
		.request(request),
		.done   (done),
		.rtcReq (rtcReq),
		.req    (req),
		.ack    (ack)
	);

endmodule

//--- tb/rtcMenu_assert.sv
// RTC menu assertions: four-phase handshake rules and sweep pause rules, bound to the top level
`timescale 1ns/1ps
`include "rtcMenu_settings.svh"

module rtcMenuAssert
(
	input logic                      CLK,
	input logic                      RST,
	input logic                      req,
	input logic                      ack,
	input rtcMenuPkg::rtcRequest_t   rtcReq,
	input logic                      start,      // Sequencer to requester
	input logic                      sweepEnd,
	input rtcMenuPkg::sweepState_t   seqState    // Sequencer FSM state
);
	import rtcMenuPkg::*;

	int assertFails = 0;    // Read by the testbench summary

	//////////////////////////////////////////////////////////////////////
	// Four-phase handshake
	//////////////////////////////////////////////////////////////////////
	reqHoldsForAck: assert property (@(posedge CLK) disable iff (RST)
		$fell(req) |-> $past(ack))
		else
		begin
			$error("req dropped before ack was raised");
			assertFails = assertFails + 1;
		end

	reqRisesOnIdleBus: assert property (@(posedge CLK) disable iff (RST)
		$rose(req) |-> !ack)
		else
		begin
			$error("req raised while ack was still high");
			assertFails = assertFails + 1;
		end

	// Request held from req rise until ack release
	requestStable: assert property (@(posedge CLK) disable iff (RST)
		(req || ack) && $past(req || ack) |-> $stable(rtcReq))
		else
		begin
			$error("rtcReq changed during a transaction");
			assertFails = assertFails + 1;
		end

	startOnIdleBus: assert property (@(posedge CLK) disable iff (RST)
		start |-> !req && !ack)
		else
		begin
			$error("start issued while an access was in flight");
			assertFails = assertFails + 1;
		end

	//////////////////////////////////////////////////////////////////////
	// Sweep rules
	//////////////////////////////////////////////////////////////////////
	pauseLength: assert property (@(posedge CLK) disable iff (RST)
		$rose(seqState == PAUSE) |-> (seqState == PAUSE)[*`WAIT_CYCLES] ##1 (seqState == ISSUE))
		else
		begin
			$error("pause between sweeps has the wrong length");
			assertFails = assertFails + 1;
		end

	sweepEndOnCommand: assert property (@(posedge CLK) disable iff (RST)
		sweepEnd |-> rtcReq.addr == `CMD_REG)
		else
		begin
			$error("sweep ended on a register other than the command register");
			assertFails = assertFails + 1;
		end

endmodule

// Attach to every top level instance, sequencer state picked from inside
bind rtcMenuTop rtcMenuAssert uAssert
(
	.CLK     (CLK),
	.RST     (RST),
	.req     (req),
	.ack     (ack),
	.rtcReq  (rtcReq),
	.start   (start),
	.sweepEnd(sweepEnd),
	.seqState(uSequencer.state)
);

//--- tb/rtcMenuTb.sv
// RTC menu testbench: RTC responder model, sweep scoreboard, cursor walk, report and watchdog
`timescale 1ns/1ps
`include "rtcMenu_settings.svh"

module rtcMenuTb;
	import rtcMenuPkg::*;

	localparam int PlannedSweeps = 14;                      // Covers cursor test time too
	localparam int TimeoutCycles = PlannedSweeps * 20 * 12;
	localparam int CursorPresses = 24;
	localparam int TimeSize      = `TIME_LAST - `TIME_FIRST + 1;
	localparam int MapSize       = TimeSize + `DATE_LAST - `DATE_FIRST + 1;

	logic                 CLK = 1'b0;
	logic                 RST;
	logic [4:0]           buttons;      // up, down, left, right, timerStart
	logic                 alarmStop;
	logic                 ack;
	logic                 req;
	rtcRequest_t          rtcReq;
	logic [`CURSOR_W-1:0] cursor;
	logic                 modifyPending;

	logic [7:0]  lfsrState = 8'd35;
	rtcRequest_t txLog[$];      // Accesses in order of req rise
	rtcAddr_t    gotAddr[$];    // One collected sweep
	logic        gotWrite[$];
	string       curTest = "reset";
	int          testErrors = 0;
	int          errorCount = 0;
	int          testsRun = 0;
	int          testsFailed = 0;
	int          lowRun;        // Idle bus cycles since ack release
	logic        lastWasCmd;
	logic        reqPrev;

	rtcMenuTop u_dut
	(
		.CLK          (CLK),
		.RST          (RST),
		.buttons      (buttons),
		.alarmStop    (alarmStop),
		.ack          (ack),
		.req          (req),
		.rtcReq       (rtcReq),
		.cursor       (cursor),
		.modifyPending(modifyPending)
	);

	always #50 CLK = ~CLK;      // 100 ns period

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////
	// Galois LFSR, taps x^8+x^6+x^5+x^4+1, one step per bit
	function automatic logic lfsrBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ 8'hB8;
		return outBit;
	endfunction

	function automatic int randBits(input int n);
		int value;
		int i;
		value = 0;
		for (i = 0; i < n; i++)
			value = (value << 1) | int'(lfsrBit());
		return value;
	endfunction

	// Cursor as a position on a ring of 11 registers
	function automatic int stepCursor(input int cur, input bit left, input bit right);
		int pos;
		pos = (cur >= `DATE_FIRST) ? TimeSize + cur - `DATE_FIRST : cur - `TIME_FIRST;
		if (left && !right)
			pos = (pos + 1) % MapSize;
		else if (right && !left)
			pos = (pos + MapSize - 1) % MapSize;
		return (pos >= TimeSize) ? `DATE_FIRST + pos - TimeSize : `TIME_FIRST + pos;
	endfunction

	task automatic checkValue(input string what, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h",
				curTest, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testErrors = 0;
	endtask

	task automatic finishTest();
		testsRun++;
		errorCount += testErrors;
		if (testErrors == 0)
			$display("PASS %s", curTest);
		else
		begin
			testsFailed++;
			$display("FAIL %s with %0d mismatches", curTest, testErrors);
		end
		testErrors = 0;
	endtask

	// Raw press for one cycle, driven on the rising edge
	task automatic pressButtons(input logic [4:0] mask);
		@(posedge CLK);
		buttons <= mask;
		@(posedge CLK);
		buttons <= '0;
	endtask

	// Pops logged accesses up to and including the command register
	task automatic collectSweep();
		rtcRequest_t entry;
		bit          closed;
		gotAddr.delete();
		gotWrite.delete();
		closed = 1'b0;
		while (!closed)
		begin
			while (txLog.size() == 0)
				@(posedge CLK);
			entry = txLog.pop_front();
			gotAddr.push_back(entry.addr);
			gotWrite.push_back(entry.write);
			closed = (entry.addr == `CMD_REG);
		end
	endtask

	// Expected walk from the register map
	// A modify press lands while the first access runs, so writes start at the second
	task automatic checkSweep(input rtcAddr_t service, input bit hasService, input bit modify);
		rtcAddr_t expAddr[$];
		logic     expWrite;
		int       i;
		for (i = `TIME_FIRST; i <= `TIME_LAST; i++)
			expAddr.push_back(rtcAddr_t'(i));
		for (i = `DATE_FIRST; i <= `DATE_LAST; i++)
			expAddr.push_back(rtcAddr_t'(i));
		if (hasService)
			expAddr.push_back(service);
		expAddr.push_back(`CMD_REG);
		checkValue("sweep length", expAddr.size(), gotAddr.size());
		for (i = 0; i < gotAddr.size(); i++)
		begin
			if (i < expAddr.size())
				checkValue($sformatf("address %0d", i), expAddr[i], gotAddr[i]);
			expWrite = modify && (i > 0);
			checkValue($sformatf("write flag at 0x%0h", gotAddr[i]), expWrite, gotWrite[i]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// RTC responder and gap monitor
	//////////////////////////////////////////////////////////////////////
	always
	begin : responder
		int ackDelay;
		@(negedge CLK);
		if (!RST && req && !ack)
		begin
			txLog.push_back(rtcReq);
			ackDelay = 1 + randBits(2);         // 1 to 4 cycles
			repeat (ackDelay) @(posedge CLK);
			ack <= 1'b1;
			do
				@(negedge CLK);
			while (req);
			@(posedge CLK);
			ack <= 1'b0;
		end
	end

	always @(negedge CLK)
	begin
		if (RST)
		begin
			lowRun     = 0;
			lastWasCmd = 1'b0;
			reqPrev    = 1'b0;
		end
		else
		begin
			if (req && !reqPrev)
			begin
				// Ack release seen, done, pause cycles, start, then req
				if (lastWasCmd && lowRun != `WAIT_CYCLES + 3)
				begin
					$display("CHECK FAILED %s sweep gap: expected %0d, actual %0d",
						curTest, `WAIT_CYCLES + 3, lowRun);
					testErrors++;
				end
				lastWasCmd = (rtcReq.addr == `CMD_REG);
				lowRun = 0;
			end
			else if (!req && !ack)
				lowRun++;
			reqPrev = req;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test flow
	//////////////////////////////////////////////////////////////////////
	initial
	begin : mainFlow
		int         n;
		int         cursorModel;
		logic [4:0] mask;
		RST       = 1'b1;
		buttons   = '0;
		alarmStop = 1'b0;
		ack       = 1'b0;
		repeat (10) @(posedge CLK);
		RST <= 1'b0;

		startTest("sweep order");
		repeat (3)
		begin
			collectSweep();
			checkSweep('0, 1'b0, 1'b0);
		end
		finishTest();

		startTest("timer service");
		pressButtons(5'b00001);                 // Lands while the command access runs
		collectSweep();
		checkSweep(`TIMER_REG, 1'b1, 1'b0);
		collectSweep();
		checkSweep('0, 1'b0, 1'b0);             // Once only
		finishTest();

		startTest("alarm service");
		@(posedge CLK);
		alarmStop <= 1'b1;
		repeat (2)
		begin
			collectSweep();
			checkSweep(`ALARM_REG, 1'b1, 1'b0);
		end
		@(posedge CLK);
		alarmStop <= 1'b0;
		collectSweep();
		checkSweep('0, 1'b0, 1'b0);
		finishTest();

		startTest("modify flag");
		for (n = 0; n < 2; n++)
		begin
			while (txLog.size() == 0)
				@(posedge CLK);                 // First access of the next sweep
			pressButtons((n == 0) ? 5'b10000 : 5'b01000);   // Up, then down
			collectSweep();
			checkSweep('0, 1'b0, 1'b1);
			collectSweep();
			checkSweep('0, 1'b0, 1'b0);         // Flag gone after sweep end
		end
		@(negedge CLK);
		checkValue("modifyPending", 0, modifyPending);
		finishTest();

		startTest("cursor walk");
		cursorModel = `TIME_FIRST;
		@(negedge CLK);
		checkValue("cursor at start", cursorModel, cursor);
		for (n = 0; n < CursorPresses; n++)
		begin
			if (n == 0 || n == 9)
				mask = 5'b00010;                // Right, over the wrap and later back over the gap
			else if (n < 9)
				mask = 5'b00100;                // Left, back over the wrap and on over the gap
			else if (n == 10)
				mask = 5'b00110;                // Both, no move
			else
			begin
				@(posedge CLK);                 // Off the negedge where the responder draws
				case (randBits(2))
					0:       mask = 5'b00100;   // Left
					1:       mask = 5'b00010;   // Right
					2:       mask = 5'b00110;   // Both, no move
					default: mask = 5'b00100;
				endcase
			end
			pressButtons(mask);
			repeat (2) @(posedge CLK);          // Third edge after the press
			@(negedge CLK);
			cursorModel = stepCursor(cursorModel, mask[2], mask[1]);
			checkValue($sformatf("cursor after press %0d", n), cursorModel, cursor);
		end
		finishTest();

		$write("Summary: %0d tests, %0d passed, %0d failed, ",
			testsRun, testsRun - testsFailed, testsFailed);
		$display("%0d check failures, %0d assertion failures",
			errorCount, u_dut.uAssert.assertFails);
		if (errorCount == 0 && testErrors == 0 && u_dut.uAssert.assertFails == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Watchdog, budget of 20 accesses of 12 cycles per planned sweep
	initial
	begin : watchdog
		#(TimeoutCycles * 100);
		$display("Timeout: the tests did not finish within %0d clock cycles", TimeoutCycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- project.f
+incdir+source
source/rtcMenuPkg.sv
source/buttonEdges.sv
source/editCursor.sv
source/sweepSequencer.sv
source/rtcBusRequester.sv
source/rtcMenuTop.sv
tb/rtcMenu_assert.sv
tb/rtcMenuTb.sv

//--- Bender.yml
package:
  name: rtc_menu

export_include_dirs:
  - source

sources:
  # RTL, package first
  - include_dirs:
      - source
    files:
      - source/rtcMenuPkg.sv
      - source/buttonEdges.sv
      - source/editCursor.sv
      - source/sweepSequencer.sv
      - source/rtcBusRequester.sv
      - source/rtcMenuTop.sv

  # Bound assertions and testbench
  - target: test
    include_dirs:
      - source
    files:
      - tb/rtcMenu_assert.sv
      - tb/rtcMenuTb.sv
